//--- source/const_pack.sv
package const_pack;

    // ADC code width per slice
    localparam int Nadc = 8;

    // time-interleaved slices per clk_adc cycle
    localparam int Nti = 16;

    // PRBS polynomial order
    localparam int Nprbs = 7;

    // bit error counter width
    localparam int Ncnt = 32;

    // command port data width, half of a counter
    localparam int Ncmd = 16;

    // command port address width
    // low bits pick a slice, high bits pick a capture word
    localparam int Naddr = 8;

endpackage

//--- source/dcore_pack.sv
package dcore_pack;

    // host command opcodes
    typedef enum logic [2:0] {
        OP_NOP          = 3'd0,
        OP_SET_OFFSET   = 3'd1,
        OP_SET_MODE     = 3'd2,
        OP_READ_OFFSET  = 3'd3,
        OP_READ_CORRECT = 3'd4,
        OP_READ_TOTAL   = 3'd5,
        OP_READ_MEM     = 3'd6
    } cmd_op_t;

    // PRBS checker counting modes
    typedef enum logic [1:0] {
        CHK_HOLD  = 2'd0,
        CHK_CLEAR = 2'd1,
        CHK_RUN   = 2'd2
    } chk_mode_t;

    // command controller FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_WAIT = 2'd2,
        ST_ACK  = 2'd3
    } ctrl_state_t;

endpackage

//--- source/dcore_debug_intf.sv
`timescale 1ns/10ps
`default_nettype none

interface dcore_debug_intf #(
    parameter int N_mem_depth = 16
) ();
    import const_pack::*;
    import dcore_pack::*;

    localparam int Nmaddr = (N_mem_depth > 1) ? $clog2(N_mem_depth) : 1;
    localparam int Nword  = Naddr - $clog2(Nti);

    // per-slice offset calibration
    logic signed [Nadc-1:0] pfd_offset [Nti];

    // checker control and status
    chk_mode_t       chk_mode;
    logic [Ncnt-1:0] correct_bits;
    logic [Ncnt-1:0] total_bits;

    // capture memory read port
    logic [Nword-1:0]       mem_word;
    logic [Nmaddr-1:0]      mem_raddr;
    logic signed [Nadc-1:0] mem_rdata [Nti];
    logic                   mem_busy;

    // word field of the command address trimmed to the memory depth
    assign mem_raddr = mem_word[Nmaddr-1:0];

    modport ctrl (
        output pfd_offset,
        output chk_mode,
        output mem_word,
        input  correct_bits,
        input  total_bits,
        input  mem_rdata,
        input  mem_busy
    );

    modport unfold (
        input pfd_offset
    );

    modport prbs (
        input  chk_mode,
        output correct_bits,
        output total_bits
    );

    modport mem (
        input  mem_raddr,
        output mem_rdata,
        output mem_busy
    );

endinterface

`default_nettype wire

//--- source/dcore_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcore_ctrl (
    input wire logic                          clk_adc,
    input wire logic                          rst_i,
    input wire logic                          cmd_req_i,
    input wire dcore_pack::cmd_op_t           cmd_op_i,
    input wire logic [const_pack::Naddr-1:0]  cmd_addr_i,
    input wire logic [const_pack::Ncmd-1:0]   cmd_data_i,
    output logic                              cmd_ack_o,
    output logic [const_pack::Ncmd-1:0]       cmd_rdata_o,
    dcore_debug_intf.ctrl                     dbg
);
    import const_pack::*;
    import dcore_pack::*;

    localparam int Nslice = $clog2(Nti);
    localparam int Nword  = Naddr - Nslice;
    localparam int Nmode  = $bits(chk_mode_t);

    ctrl_state_t            state;
    logic                   req_q;
    cmd_op_t                op_q;
    logic [Naddr-1:0]       addr_q;
    logic signed [Nadc-1:0] offset_q [Nti];
    chk_mode_t              mode_q;
    logic [Nslice-1:0]      sel;
    logic signed [Nadc-1:0] sel_offset;
    logic signed [Nadc-1:0] sel_code;
    logic [Ncmd-1:0]        rdata_next;

    assign dbg.pfd_offset = offset_q;
    assign dbg.chk_mode   = mode_q;
    assign cmd_ack_o      = (state == ST_ACK);

    // read word selection, captured into cmd_rdata_o in WAIT
    always_comb begin
        sel        = addr_q[Nslice-1:0];
        sel_offset = offset_q[sel];
        sel_code   = dbg.mem_rdata[sel];
        case (op_q)
            // status word: mode and capture busy flag
            OP_NOP:
                rdata_next = {{(Ncmd-Nmode-1){1'b0}}, mode_q, dbg.mem_busy};
            OP_READ_OFFSET:
                rdata_next = {{(Ncmd-Nadc){sel_offset[Nadc-1]}}, sel_offset};
            OP_READ_CORRECT:
                rdata_next = addr_q[0] ? dbg.correct_bits[Ncnt-1 -: Ncmd]
                                       : dbg.correct_bits[Ncmd-1:0];
            OP_READ_TOTAL:
                rdata_next = addr_q[0] ? dbg.total_bits[Ncnt-1 -: Ncmd]
                                       : dbg.total_bits[Ncmd-1:0];
            OP_READ_MEM:
                rdata_next = {{(Ncmd-Nadc){sel_code[Nadc-1]}}, sel_code};
            default:
                rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            req_q        <= 1'b0;
            state        <= ST_IDLE;
            op_q         <= OP_NOP;
            addr_q       <= '0;
            mode_q       <= CHK_HOLD;
            cmd_rdata_o  <= '0;
            dbg.mem_word <= '0;
            for (int k = 0; k < Nti; k++) begin
                offset_q[k] <= '0;
            end
        end else begin
            // registered request line
            req_q <= cmd_req_i;
            case (state)
                ST_IDLE: begin
                    if (req_q) begin
                        // start the memory read early to cover its latency
                        dbg.mem_word <= cmd_addr_i[Naddr-1 -: Nword];
                        state        <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    op_q   <= cmd_op_i;
                    addr_q <= cmd_addr_i;
                    if (cmd_op_i == OP_SET_OFFSET) begin
                        offset_q[cmd_addr_i[Nslice-1:0]] <= cmd_data_i[Nadc-1:0];
                    end
                    if (cmd_op_i == OP_SET_MODE) begin
                        mode_q <= chk_mode_t'(cmd_data_i[Nmode-1:0]);
                    end
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    cmd_rdata_o <= rdata_next;
                    state       <= ST_ACK;
                end
                ST_ACK: begin
                    // hold ack until the host releases req
                    if (!req_q) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/adc_unfolding.sv
`timescale 1ns/10ps
`default_nettype none

module adc_unfolding #(
    parameter int slice_idx = 0
) (
    input wire logic                               clk_adc,
    input wire logic                               rst_i,
    input wire logic [const_pack::Nadc-1:0]        din_i,
    input wire logic                               sign_i,
    dcore_debug_intf.unfold                        dbg,
    output logic signed [const_pack::Nadc-1:0]     dout_o
);
    import const_pack::*;

    // two guard bits cover the negated magnitude minus the offset
    localparam int Nwide = Nadc + 2;
    localparam logic signed [Nwide-1:0] code_max = Nwide'(2**(Nadc-1) - 1);
    localparam logic signed [Nwide-1:0] code_min = -code_max - 1;

    logic signed [Nadc-1:0]  offset;
    logic signed [Nwide-1:0] mag_s;
    logic signed [Nwide-1:0] val_s;
    logic signed [Nwide-1:0] diff_s;

    assign offset = dbg.pfd_offset[slice_idx];

    always_comb begin
        mag_s = $signed({2'b00, din_i});
        // sign bit high means a positive code
        val_s  = sign_i ? mag_s : -mag_s;
        diff_s = val_s - {{2{offset[Nadc-1]}}, offset};
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            dout_o <= '0;
        end else if (diff_s > code_max) begin
            dout_o <= code_max[Nadc-1:0];
        end else if (diff_s < code_min) begin
            dout_o <= code_min[Nadc-1:0];
        end else begin
            dout_o <= diff_s[Nadc-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/prbs_checker.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_checker #(
    parameter int n_prbs = const_pack::Nprbs
) (
    input wire logic                       clk_adc,
    input wire logic                       rst_i,
    input wire logic [const_pack::Nti-1:0] rx_bits_i,
    dcore_debug_intf.prbs                  dbg
);
    import const_pack::*;
    import dcore_pack::*;

    localparam int Nmatch = $clog2(Nti + 1);

    // hist[0] is the oldest bit of the previous word
    logic [n_prbs-1:0]      hist;
    logic [Nti+n_prbs-1:0]  stream;
    logic [Nti-1:0]         pred;
    logic [Nti-1:0]         match;
    logic [Nmatch-1:0]      match_cnt;

    // serial order is history first, then lane 0 upward
    assign stream = {rx_bits_i, hist};

    // lane k sits at stream[k+n_prbs]
    // taps at n-n_prbs and n-(n_prbs-1)
    always_comb begin
        match_cnt = '0;
        for (int k = 0; k < Nti; k++) begin
            pred[k]   = stream[k] ^ stream[k+1];
            match[k]  = ~(pred[k] ^ rx_bits_i[k]);
            match_cnt = match_cnt + Nmatch'(match[k]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist             <= '0;
            dbg.correct_bits <= '0;
            dbg.total_bits   <= '0;
        end else begin
            // self-synchronizing, history follows the received stream
            hist <= stream[Nti +: n_prbs];
            case (dbg.chk_mode)
                CHK_RUN: begin
                    dbg.correct_bits <= dbg.correct_bits + Ncnt'(match_cnt);
                    dbg.total_bits   <= dbg.total_bits + Ncnt'(Nti);
                end
                CHK_CLEAR: begin
                    dbg.correct_bits <= '0;
                    dbg.total_bits   <= '0;
                end
                default: begin
                    dbg.correct_bits <= dbg.correct_bits;
                    dbg.total_bits   <= dbg.total_bits;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/oneshot_memory.sv
`timescale 1ns/10ps
`default_nettype none

module oneshot_memory #(
    parameter int N_mem_depth = 16
) (
    input wire logic                                clk_adc,
    input wire logic                                rst_i,
    input wire logic                                start_i,
    input wire logic signed [const_pack::Nadc-1:0]  codes_i [const_pack::Nti],
    dcore_debug_intf.mem                            dbg
);
    import const_pack::*;

    localparam int Nmaddr = (N_mem_depth > 1) ? $clog2(N_mem_depth) : 1;

    logic signed [Nadc-1:0] mem [N_mem_depth][Nti];
    logic [Nmaddr-1:0]      waddr;
    logic                   start_q;
    logic                   start_rise;

    assign start_rise = start_i & ~start_q;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            start_q      <= 1'b0;
            waddr        <= '0;
            dbg.mem_busy <= 1'b0;
        end else begin
            start_q <= start_i;
            if (dbg.mem_busy) begin
                if (waddr == Nmaddr'(N_mem_depth - 1)) begin
                    waddr        <= '0;
                    dbg.mem_busy <= 1'b0;
                end else begin
                    waddr <= waddr + 1'b1;
                end
            end else if (start_rise) begin
                // edges during a capture are ignored
                waddr        <= '0;
                dbg.mem_busy <= 1'b1;
            end
        end
    end

    // one word per cycle while busy
    always_ff @(posedge clk_adc) begin
        if (dbg.mem_busy) begin
            mem[waddr] <= codes_i;
        end
    end

    // synchronous read, one cycle of latency
    always_ff @(posedge clk_adc) begin
        dbg.mem_rdata <= mem[dbg.mem_raddr];
    end

endmodule

`default_nettype wire

//--- source/digital_core.sv
`timescale 1ns/10ps
`default_nettype none

module digital_core #(
    parameter int N_mem_depth = 16
) (
    input wire logic                                          clk_adc,
    input wire logic                                          rst_i,
    input wire logic [const_pack::Nti*const_pack::Nadc-1:0]   adcout_i,
    input wire logic [const_pack::Nti-1:0]                    adcout_sign_i,
    input wire logic                                          dump_start_i,
    input wire logic                                          cmd_req_i,
    input wire dcore_pack::cmd_op_t                           cmd_op_i,
    input wire logic [const_pack::Naddr-1:0]                  cmd_addr_i,
    input wire logic [const_pack::Ncmd-1:0]                   cmd_data_i,
    output logic                                              cmd_ack_o,
    output logic [const_pack::Ncmd-1:0]                       cmd_rdata_o,
    output logic [const_pack::Nti*const_pack::Nadc-1:0]       codes_o
);
    import const_pack::*;

    dcore_debug_intf #(.N_mem_depth(N_mem_depth)) ddbg_intf_i ();

    logic signed [Nadc-1:0] codes [Nti];
    logic [Nti-1:0]         rx_bits;

    dcore_ctrl dcore_ctrl_i (
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .cmd_req_i   (cmd_req_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_data_i  (cmd_data_i),
        .cmd_ack_o   (cmd_ack_o),
        .cmd_rdata_o (cmd_rdata_o),
        .dbg         (ddbg_intf_i)
    );

    genvar k;
    generate
        for (k = 0; k < Nti; k = k + 1) begin : unfold_by_slice
            adc_unfolding #(.slice_idx(k)) adc_unfolding_i (
                .clk_adc (clk_adc),
                .rst_i   (rst_i),
                .din_i   (adcout_i[k*Nadc +: Nadc]),
                .sign_i  (adcout_sign_i[k]),
                .dbg     (ddbg_intf_i),
                .dout_o  (codes[k])
            );

            assign codes_o[k*Nadc +: Nadc] = codes[k];
            // non-negative code decodes as a one
            assign rx_bits[k] = ~codes[k][Nadc-1];
        end
    endgenerate

    prbs_checker #(.n_prbs(Nprbs)) prbs_checker_i (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .rx_bits_i (rx_bits),
        .dbg       (ddbg_intf_i)
    );

    oneshot_memory #(.N_mem_depth(N_mem_depth)) oneshot_memory_i (
        .clk_adc (clk_adc),
        .rst_i   (rst_i),
        .start_i (dump_start_i),
        .codes_i (codes),
        .dbg     (ddbg_intf_i)
    );

endmodule

`default_nettype wire

//--- verif/digital_core_checker.sv
`timescale 1ns/10ps

module digital_core_checker (
    input logic                          clk_adc,
    input logic                          rst_i,
    input logic                          req_i,
    input logic                          ack_i,
    input logic [const_pack::Ncmd-1:0]   rdata_i,
    input dcore_pack::ctrl_state_t       state_i
);
    import dcore_pack::*;

    int fail_cnt = 0;

    // reset parks the FSM in idle with ack low
    ack_low_in_reset: assert property (
        @(posedge clk_adc) rst_i |=> (state_i == ST_IDLE) && !ack_i
    ) else begin
        $error("ack or state not cleared by reset");
        fail_cnt++;
    end

    ack_rise_with_req: assert property (
        @(posedge clk_adc) disable iff (rst_i) $rose(ack_i) |-> req_i
    ) else begin
        $error("ack rose without a pending request");
        fail_cnt++;
    end

    // host must have released req before ack drops
    ack_fall_after_req: assert property (
        @(posedge clk_adc) disable iff (rst_i) $fell(ack_i) |-> !$past(req_i)
    ) else begin
        $error("ack fell while req was still high");
        fail_cnt++;
    end

    rdata_stable_in_ack: assert property (
        @(posedge clk_adc) disable iff (rst_i) ack_i && $past(ack_i) |-> $stable(rdata_i)
    ) else begin
        $error("read data changed while ack was high");
        fail_cnt++;
    end

endmodule

bind dcore_ctrl digital_core_checker ctrl_checker_i (
    .clk_adc (clk_adc),
    .rst_i   (rst_i),
    .req_i   (cmd_req_i),
    .ack_i   (cmd_ack_o),
    .rdata_i (cmd_rdata_o),
    .state_i (state)
);

//--- verif/digital_core_tb.sv
`timescale 1ns/10ps

module digital_core_tb;
    import const_pack::*;
    import dcore_pack::*;

    localparam int mem_depth = 16;
    localparam int Nsel = $clog2(Nti);
    localparam int n_vec = 64;
    localparam int n_words = 40;
    localparam logic [Nadc-1:0] stream_mag = 8'd96;

    // one command is eight cycles from request to ack low
    localparam int cmd_len = 8;
    localparam int test1_len = 21 * cmd_len;
    localparam int test2_len = 32 * cmd_len + 2 * n_vec;
    localparam int test3_len = 7 * cmd_len + n_words + 4;
    localparam int test4_len = 11 * cmd_len + 42;
    localparam int test5_len = (mem_depth * Nti) * cmd_len + 2 * mem_depth + 4;
    localparam int test_len = test1_len + test2_len + test3_len + test4_len + test5_len;
    localparam int cycle_limit = test_len + test_len / 4 + 100;

    logic                   clk_adc;
    logic                   rst;
    logic [Nti*Nadc-1:0]    adcout;
    logic [Nti-1:0]         adcout_sign;
    logic                   dump_start;
    logic                   cmd_req;
    cmd_op_t                cmd_op;
    logic [Naddr-1:0]       cmd_addr;
    logic [Ncmd-1:0]        cmd_data;
    logic                   cmd_ack;
    logic [Ncmd-1:0]        cmd_rdata;
    logic [Nti*Nadc-1:0]    codes;

    // reference model state
    logic signed [Nadc-1:0] model_offset [Nti];
    logic signed [Nadc-1:0] exp_code [Nti];
    chk_mode_t              model_mode;
    logic [Nprbs-1:0]       chk_win;
    logic [Ncnt-1:0]        model_correct;
    logic [Ncnt-1:0]        model_total;
    int                     run_words;

    logic [Nprbs-1:0]       gen_win;
    logic                   stream_on;
    logic [Nti-1:0]         flip_mask;
    logic [31:0]            rng_state;
    int                     cycle_cnt;

    digital_core #(.N_mem_depth(mem_depth)) uut (
        .clk_adc       (clk_adc),
        .rst_i         (rst),
        .adcout_i      (adcout),
        .adcout_sign_i (adcout_sign),
        .dump_start_i  (dump_start),
        .cmd_req_i     (cmd_req),
        .cmd_op_i      (cmd_op),
        .cmd_addr_i    (cmd_addr),
        .cmd_data_i    (cmd_data),
        .cmd_ack_o     (cmd_ack),
        .cmd_rdata_o   (cmd_rdata),
        .codes_o       (codes)
    );

    always #4 clk_adc = ~clk_adc;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk_adc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_with_failure($sformatf("simulation ran past %0d cycles", cycle_limit));
        end else if (uut.dcore_ctrl_i.ctrl_checker_i.fail_cnt != 0) begin
            stop_with_failure("controller handshake assertions failed");
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // sign high keeps the magnitude before offset and clamp
    function automatic logic signed [Nadc-1:0] ref_code(input logic [Nadc-1:0] mag,
                                                        input logic sign,
                                                        input logic signed [Nadc-1:0] off);
        int v;
        int hi;
        int lo;
        hi = 2**(Nadc-1) - 1;
        lo = -(2**(Nadc-1));
        v = sign ? int'(mag) : -int'(mag);
        v = v - int'(off);
        if (v > hi) begin
            v = hi;
        end else if (v < lo) begin
            v = lo;
        end
        return Nadc'(v);
    endfunction

    task automatic compare_code(input string name, input logic signed [Nadc-1:0] act,
                                input logic signed [Nadc-1:0] exp);
        if (act !== exp) begin
            stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d",
                                        $time, name, act, exp));
        end
    endtask

    task automatic compare_word(input string name, input logic [Ncmd-1:0] act,
                                input logic [Ncmd-1:0] exp);
        if (act !== exp) begin
            stop_with_failure($sformatf("error at %0t: %s is 0x%04h, expected 0x%04h",
                                        $time, name, act, exp));
        end
    endtask

    task automatic compare_count(input string name, input logic [Ncnt-1:0] act,
                                 input logic [Ncnt-1:0] exp);
        if (act !== exp) begin
            stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d",
                                        $time, name, act, exp));
        end
    endtask

    // PRBS7 source with lane 0 first and the bit carried in the sign
    always @(posedge clk_adc) begin : stream_gen
        logic [Nti-1:0] bits;
        logic b;
        if (stream_on) begin
            for (int k = 0; k < Nti; k++) begin
                b = gen_win[Nprbs-2] ^ gen_win[Nprbs-1];
                bits[k] = b;
                gen_win = {gen_win[Nprbs-2:0], b};
            end
            adcout <= {Nti{stream_mag}};
            adcout_sign <= bits ^ flip_mask;
        end
    end

    // win[0] is the newest received bit
    always @(posedge clk_adc) begin : ref_model
        logic [Nprbs-1:0] win;
        logic rx;
        int hits;
        if (rst) begin
            chk_win <= '0;
            model_correct <= '0;
            model_total <= '0;
            run_words <= 0;
            for (int k = 0; k < Nti; k++) begin
                exp_code[k] <= '0;
            end
        end else begin
            win = chk_win;
            hits = 0;
            for (int k = 0; k < Nti; k++) begin
                rx = ~exp_code[k][Nadc-1];
                if ((win[Nprbs-2] ^ win[Nprbs-1]) == rx) begin
                    hits++;
                end
                win = {win[Nprbs-2:0], rx};
            end
            chk_win <= win;
            case (model_mode)
                CHK_RUN: begin
                    model_correct <= model_correct + Ncnt'(hits);
                    model_total <= model_total + Ncnt'(Nti);
                    run_words <= run_words + 1;
                end
                CHK_CLEAR: begin
                    model_correct <= '0;
                    model_total <= '0;
                    run_words <= 0;
                end
                default: ;
            endcase
            for (int k = 0; k < Nti; k++) begin
                exp_code[k] <= ref_code(adcout[k*Nadc +: Nadc], adcout_sign[k], model_offset[k]);
            end
        end
    end

    task automatic do_cmd(input cmd_op_t op, input logic [Naddr-1:0] addr,
                          input logic [Ncmd-1:0] data, output logic [Ncmd-1:0] rdata);
        int lat;
        int wait_cnt;
        @(posedge clk_adc);
        cmd_req <= 1'b1;
        cmd_op <= op;
        cmd_addr <= addr;
        cmd_data <= data;
        // this edge samples the request
        @(posedge clk_adc);
        lat = 0;
        do begin
            @(posedge clk_adc);
            lat++;
            // new settings apply from the cycle after the EXEC edge
            if (lat == 2 && op == OP_SET_OFFSET) begin
                model_offset[addr[Nsel-1:0]] <= data[Nadc-1:0];
            end
            if (lat == 2 && op == OP_SET_MODE) begin
                model_mode <= chk_mode_t'(data[$bits(chk_mode_t)-1:0]);
            end
            @(negedge clk_adc);
            if (lat > cmd_len) begin
                stop_with_failure("no command ack within 8 cycles of the request");
            end
        end while (!cmd_ack);
        if (lat != 3) begin
            stop_with_failure($sformatf("command ack came %0d cycles after the request, not 3",
                                        lat));
        end
        rdata = cmd_rdata;
        if (op == OP_SET_OFFSET || op == OP_SET_MODE) begin
            compare_word("cmd_rdata_o", rdata, '0);
        end
        @(posedge clk_adc);
        cmd_req <= 1'b0;
        wait_cnt = 0;
        do begin
            @(negedge clk_adc);
            wait_cnt++;
            if (wait_cnt > cmd_len) begin
                stop_with_failure("command ack stayed high after the request was dropped");
            end
        end while (cmd_ack);
    endtask

    task automatic read_count(input cmd_op_t op, output logic [Ncnt-1:0] value);
        logic [Ncmd-1:0] lo;
        logic [Ncmd-1:0] hi;
        do_cmd(op, Naddr'(0), '0, lo);
        do_cmd(op, Naddr'(1), '0, hi);
        value = {hi, lo};
    endtask

    task automatic set_mode(input chk_mode_t mode);
        logic [Ncmd-1:0] rd;
        do_cmd(OP_SET_MODE, '0, Ncmd'(mode), rd);
    endtask

    task automatic check_reset_state();
        logic [Ncnt-1:0] cnt;
        logic [Ncmd-1:0] rd;
        @(negedge clk_adc);
        if (cmd_ack !== 1'b0) begin
            stop_with_failure("command ack is not low after reset");
        end
        compare_word("cmd_rdata_o", cmd_rdata, '0);
        // status word is zero with the checker held and no capture running
        do_cmd(OP_NOP, '0, '0, rd);
        compare_word("status word", rd, '0);
        read_count(OP_READ_CORRECT, cnt);
        compare_count("correct_bits", cnt, '0);
        read_count(OP_READ_TOTAL, cnt);
        compare_count("total_bits", cnt, '0);
        for (int k = 0; k < Nti; k++) begin
            do_cmd(OP_READ_OFFSET, Naddr'(k), '0, rd);
            compare_word($sformatf("offset[%0d]", k), rd, '0);
        end
    endtask

    task automatic check_unfolding();
        logic signed [Nadc-1:0] off [Nti];
        logic [Nadc-1:0]        mag [Nti];
        logic [Nti-1:0]         sign;
        logic [Nti*Nadc-1:0]    flat;
        logic [31:0]            r;
        logic [Ncmd-1:0]        rd;
        // small offsets keep the stream signs intact later on
        for (int k = 0; k < Nti; k++) begin
            r = next_rand();
            off[k] = {{(Nadc-6){r[5]}}, r[5:0]};
            do_cmd(OP_SET_OFFSET, Naddr'(k), Ncmd'(off[k]), rd);
        end
        for (int i = 0; i < n_vec; i++) begin
            for (int k = 0; k < Nti; k++) begin
                r = next_rand();
                mag[k] = r[Nadc-1:0];
                flat[k*Nadc +: Nadc] = mag[k];
            end
            r = next_rand();
            sign = r[Nti-1:0];
            @(posedge clk_adc);
            adcout <= flat;
            adcout_sign <= sign;
            @(posedge clk_adc);
            @(negedge clk_adc);
            for (int k = 0; k < Nti; k++) begin
                compare_code($sformatf("codes_o[%0d]", k), codes[k*Nadc +: Nadc],
                             ref_code(mag[k], sign[k], off[k]));
            end
        end
        for (int k = 0; k < Nti; k++) begin
            do_cmd(OP_READ_OFFSET, Naddr'(k), '0, rd);
            compare_word($sformatf("offset[%0d]", k), rd, Ncmd'(off[k]));
        end
    endtask

    task automatic check_prbs_count();
        logic [Ncnt-1:0] cnt;
        @(posedge clk_adc);
        stream_on <= 1'b1;
        repeat (2) @(posedge clk_adc);
        // history is already filled when the clear lands
        set_mode(CHK_CLEAR);
        set_mode(CHK_RUN);
        repeat (n_words) @(posedge clk_adc);
        set_mode(CHK_HOLD);
        read_count(OP_READ_TOTAL, cnt);
        compare_count("total_bits", cnt, Ncnt'(Nti * run_words));
        read_count(OP_READ_CORRECT, cnt);
        compare_count("correct_bits", cnt, Ncnt'(Nti * run_words));
    endtask

    task automatic check_prbs_error();
        logic [Ncnt-1:0] correct;
        logic [Ncnt-1:0] total;
        logic [Ncnt-1:0] cnt;
        set_mode(CHK_CLEAR);
        set_mode(CHK_RUN);
        repeat (10) @(posedge clk_adc);
        @(posedge clk_adc);
        flip_mask <= Nti'(1) << 8;
        @(posedge clk_adc);
        flip_mask <= '0;
        repeat (10) @(posedge clk_adc);
        set_mode(CHK_HOLD);
        read_count(OP_READ_CORRECT, correct);
        compare_count("correct_bits", correct, model_correct);
        read_count(OP_READ_TOTAL, total);
        compare_count("total_bits", total, model_total);
        if (total - correct < 1 || total - correct > 3) begin
            stop_with_failure($sformatf("one flipped bit cost %0d correct bits, not 1 to 3",
                                        total - correct));
        end
        repeat (20) @(posedge clk_adc);
        read_count(OP_READ_CORRECT, cnt);
        compare_count("correct_bits", cnt, correct);
        read_count(OP_READ_TOTAL, cnt);
        compare_count("total_bits", cnt, total);
    endtask

    task automatic check_capture();
        logic signed [Nadc-1:0] rec [mem_depth][Nti];
        logic [Ncmd-1:0]        rd;
        @(posedge clk_adc);
        dump_start <= 1'b1;
        // edge that sees the rising start
        @(posedge clk_adc);
        for (int i = 0; i < mem_depth; i++) begin
            @(negedge clk_adc);
            for (int k = 0; k < Nti; k++) begin
                rec[i][k] = exp_code[k];
                compare_code($sformatf("codes_o[%0d]", k), codes[k*Nadc +: Nadc], exp_code[k]);
            end
            @(posedge clk_adc);
            // second edge lands mid capture
            if (i == 1) begin
                dump_start <= 1'b0;
            end
            if (i == 3) begin
                dump_start <= 1'b1;
            end
        end
        for (int w = 0; w < mem_depth; w++) begin
            for (int k = 0; k < Nti; k++) begin
                do_cmd(OP_READ_MEM, Naddr'(w * Nti + k), '0, rd);
                compare_word($sformatf("mem word %0d slice %0d", w, k), rd, Ncmd'(rec[w][k]));
            end
        end
    endtask

    initial begin
        clk_adc = 1'b0;
        rst = 1'b1;
        adcout = '0;
        adcout_sign = '0;
        dump_start = 1'b0;
        cmd_req = 1'b0;
        cmd_op = OP_NOP;
        cmd_addr = '0;
        cmd_data = '0;
        rng_state = 32'd86780;
        gen_win = '1;
        stream_on = 1'b0;
        flip_mask = '0;
        model_mode = CHK_HOLD;
        cycle_cnt = 0;
        for (int k = 0; k < Nti; k++) begin
            model_offset[k] = '0;
        end
        repeat (4) @(posedge clk_adc);
        rst <= 1'b0;
        check_reset_state();
        check_unfolding();
        check_prbs_count();
        check_prbs_error();
        check_capture();
        @(posedge clk_adc);
        if (uut.dcore_ctrl_i.ctrl_checker_i.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_failure("controller handshake assertions failed");
        end
    end

endmodule

//--- verilog.f
source/const_pack.sv
source/dcore_pack.sv
source/dcore_debug_intf.sv
source/dcore_ctrl.sv
source/adc_unfolding.sv
source/prbs_checker.sv
source/oneshot_memory.sv
source/digital_core.sv
verif/digital_core_checker.sv
verif/digital_core_tb.sv
